// File: rtl/mshr_consts.svh
// -------------------
// Size constants of the L1 data cache miss tracking
// Included by the package and by the MSHR register file
// -------------------

`ifndef MSHR_CONSTS_SVH
`define MSHR_CONSTS_SVH

// Number of MSHR entries
// Any power of two of 2 or more
`define L1C_MSHR_ENTRIES 4

// Width of a cache line address
// Byte offset inside the line is already stripped
`define LINE_ADDR_W 26

`endif

// File: rtl/memory_pkg.sv
// -------------------
// Shared types of the L1 data cache miss unit
// Line address, pending count and the strobe groups
// between pipeline, MSHR and L2
// -------------------

`include "mshr_consts.svh"

package memory_pkg;

  // Cache line address
  typedef logic [`LINE_ADDR_W-1:0] line_addr_t;

  // Count of valid and waiting entries, 0 up to the entry count
  typedef logic [$clog2(`L1C_MSHR_ENTRIES):0] mshr_pending_req_t;

  // Miss from the d1 stage of the pipeline
  typedef struct packed {
    logic       valid;
    line_addr_t line_addr;
  } miss_req_t;

  // Returning line from L2
  typedef struct packed {
    logic       valid;
    line_addr_t line_addr;
  } refill_t;

  // Line read request toward L2
  typedef struct packed {
    logic       valid;
    line_addr_t line_addr;
  } l2_req_t;

endpackage

// File: rtl/one_hot_encoder.sv
// -------------------
// Priority encoder returning the lowest set bit index
// Zero when no bit is set, callers qualify with their own any-set
// -------------------

`timescale 1ns/1ps

module one_hot_encoder #(
  parameter int D = 4,
  parameter int E = 2
) (
  input  logic [D-1:0] mh_decoded_i,
  output logic [E-1:0] oh_encoded_o
);

  // Scan from the top down so the lowest set bit is written last
  always_comb begin
    oh_encoded_o = '0;
    for (int k = D - 1; k >= 0; k--) begin
      if (mh_decoded_i[k]) begin
        oh_encoded_o = E'(k);
      end
    end
  end

  // Output must be able to index every input bit
  initial begin
    assert (2 ** E >= D)
      else $error("one_hot_encoder output too narrow for input");
  end

endmodule

// File: rtl/dcache_mshr.sv
// -------------------
// Miss status holding registers of the L1 data cache
// One entry per outstanding line, driven by single operations
// from the miss controller, one per clock edge
// -------------------

`timescale 1ns/1ps

`include "mshr_consts.svh"

module dcache_mshr (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Operations, priority clear-all > add > put-wait > clear-hit
  input  logic                          clr_all_i,
  input  logic                          add_line_addr_i,
  input  logic                          put_wait_read_line_i,
  input  logic                          clr_hit_line_i,
  // Compare address, also the line written on add
  input  memory_pkg::line_addr_t        line_addr_i,
  // Next line still to be requested from L2
  output memory_pkg::line_addr_t        mshr_l2c_line_addr_o,
  // State
  output logic                          hit_o,
  output logic                          req_available_o,
  output logic                          full_o,
  output memory_pkg::mshr_pending_req_t pending_req_o
);

  localparam int ENTRIES = `L1C_MSHR_ENTRIES;
  localparam int IDX_W   = $clog2(ENTRIES);

  // Stored line addresses
  memory_pkg::line_addr_t line_addr_q [ENTRIES];

  // Entry holds a miss
  logic [ENTRIES-1:0] valid_q;
  // Request for the entry has gone to L2
  logic [ENTRIES-1:0] wait_q;

  // Entry match on the compare address
  logic [ENTRIES-1:0] hit_vec;
  // Free entries
  logic [ENTRIES-1:0] free_vec;
  // Valid but not yet requested
  logic [ENTRIES-1:0] ready_vec;
  // Valid and requested, counted as pending
  logic [ENTRIES-1:0] pending_vec;

  // Selected entries for each operation
  logic [IDX_W-1:0] new_idx;
  logic [IDX_W-1:0] req_idx;
  logic [IDX_W-1:0] hit_idx;

  // Valid and wait bits follow the prioritized operations
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      wait_q  <= '0;
    end else if (clr_all_i) begin
      valid_q <= '0;
      wait_q  <= '0;
    end else if (add_line_addr_i) begin
      valid_q[new_idx] <= 1'b1;
      wait_q[new_idx]  <= 1'b0;
    end else if (put_wait_read_line_i) begin
      wait_q[req_idx] <= 1'b1;
    end else if (clr_hit_line_i) begin
      valid_q[hit_idx] <= 1'b0;
      wait_q[hit_idx]  <= 1'b0;
    end
  end

  // Address payload, only written when an add is applied
  always_ff @(posedge clk_i) begin
    if (add_line_addr_i && !clr_all_i) begin
      line_addr_q[new_idx] <= line_addr_i;
    end
  end

  // Compare the presented line against every valid entry
  always_comb begin
    for (int k = 0; k < ENTRIES; k++) begin
      hit_vec[k] = valid_q[k] && (line_addr_q[k] == line_addr_i);
    end
  end

  assign free_vec    = ~valid_q;
  assign ready_vec   = valid_q & ~wait_q;
  assign pending_vec = valid_q & wait_q;

  // Lowest free slot for the next add
  one_hot_encoder #(
    .D(ENTRIES),
    .E(IDX_W)
  ) free_encoder_inst (
    .mh_decoded_i(free_vec),
    .oh_encoded_o(new_idx)
  );

  // Lowest entry still to be requested
  one_hot_encoder #(
    .D(ENTRIES),
    .E(IDX_W)
  ) req_encoder_inst (
    .mh_decoded_i(ready_vec),
    .oh_encoded_o(req_idx)
  );

  // Entry that matched the compare address
  one_hot_encoder #(
    .D(ENTRIES),
    .E(IDX_W)
  ) hit_encoder_inst (
    .mh_decoded_i(hit_vec),
    .oh_encoded_o(hit_idx)
  );

  assign mshr_l2c_line_addr_o = line_addr_q[req_idx];
  assign hit_o                = |hit_vec;
  assign req_available_o      = |ready_vec;
  assign full_o               = &valid_q;

  // Population count of the requested entries
  always_comb begin
    pending_req_o = '0;
    for (int k = 0; k < ENTRIES; k++) begin
      if (pending_vec[k]) begin
        pending_req_o = pending_req_o + memory_pkg::mshr_pending_req_t'(1);
      end
    end
  end

  // A line is never held twice, merges keep the entries distinct
  a_hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_vec)
  );

  // Controller must stall new lines once every slot is taken
  a_no_add_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (add_line_addr_i && !clr_all_i) |-> !full_o
  );

  // Requests only go out for an entry that is still unrequested
  a_put_wait_avail: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (put_wait_read_line_i && !clr_all_i && !add_line_addr_i) |-> req_available_o
  );

endmodule

// File: rtl/dcache_miss_ctrl.sv
// -------------------
// Miss controller of the L1 data cache
// Turns misses, refills and L2 slots into one MSHR operation
// per cycle, purely combinational
// -------------------

`timescale 1ns/1ps

module dcache_miss_ctrl (
  // Pipeline and L2 side
  input  logic                   flush_i,
  input  memory_pkg::miss_req_t  miss_i,
  input  memory_pkg::refill_t    refill_i,
  input  logic                   l2_stall_i,
  // MSHR state
  input  logic                   mshr_hit_i,
  input  logic                   mshr_req_available_i,
  input  logic                   mshr_full_i,
  input  memory_pkg::line_addr_t mshr_req_addr_i,
  // MSHR operations
  output logic                   mshr_clr_all_o,
  output logic                   mshr_add_o,
  output logic                   mshr_put_wait_o,
  output logic                   mshr_clr_hit_o,
  output memory_pkg::line_addr_t mshr_cmp_addr_o,
  // Responses
  output logic                   stall_o,
  output logic                   merged_o,
  output memory_pkg::l2_req_t    l2_req_o
);

  // Refill owns the single compare port when present
  logic refill_act;
  // Miss that can use the compare result this cycle
  logic miss_act;
  // Request slot toward L2
  logic req_go;

  assign refill_act = refill_i.valid && !flush_i;
  assign miss_act   = miss_i.valid && !flush_i && !refill_i.valid;

  // Compare address shared between refill and miss
  assign mshr_cmp_addr_o = refill_i.valid ? refill_i.line_addr : miss_i.line_addr;

  // Flush wipes every entry
  assign mshr_clr_all_o = flush_i;

  // Refill retires only a matching entry
  // Without a match the hit encoder would point at entry 0
  assign mshr_clr_hit_o = refill_act && mshr_hit_i;

  // Secondary miss joins the outstanding line
  assign merged_o = miss_act && mshr_hit_i;

  // Primary miss takes a free slot
  assign mshr_add_o = miss_act && !mshr_hit_i && !mshr_full_i;

  // Miss held upstream on flush, refill or a full MSHR
  always_comb begin
    stall_o = 1'b0;
    if (miss_i.valid) begin
      if (flush_i || refill_i.valid) begin
        stall_o = 1'b1;
      end else if (!mshr_hit_i && mshr_full_i) begin
        stall_o = 1'b1;
      end
    end
  end

  // L2 request only in cycles with no other MSHR operation
  assign req_go = mshr_req_available_i && !l2_stall_i && !flush_i
                  && !refill_i.valid && !mshr_add_o;

  // Entry is marked waiting on the same edge as the request
  assign mshr_put_wait_o = req_go;

  assign l2_req_o.valid     = req_go;
  assign l2_req_o.line_addr = mshr_req_addr_i;

endmodule

// File: rtl/dcache_miss_unit.sv
// -------------------
// Top of the L1 data cache miss unit
// Connects the miss controller and the MSHR between
// the cache pipeline and L2
// -------------------

`timescale 1ns/1ps

module dcache_miss_unit (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  memory_pkg::miss_req_t         miss_i,
  input  memory_pkg::refill_t           refill_i,
  input  logic                          l2_stall_i,
  output logic                          stall_o,
  output logic                          merged_o,
  output memory_pkg::l2_req_t           l2_req_o,
  output logic                          full_o,
  output memory_pkg::mshr_pending_req_t pending_o
);

  // Controller to MSHR operations
  logic                   clr_all;
  logic                   add_line;
  logic                   put_wait;
  logic                   clr_hit;
  memory_pkg::line_addr_t cmp_addr;

  // MSHR state back to the controller
  logic                   hit;
  logic                   req_available;
  memory_pkg::line_addr_t req_addr;

  dcache_miss_ctrl dcache_miss_ctrl_inst (
    .flush_i             (flush_i),
    .miss_i              (miss_i),
    .refill_i            (refill_i),
    .l2_stall_i          (l2_stall_i),
    .mshr_hit_i          (hit),
    .mshr_req_available_i(req_available),
    .mshr_full_i         (full_o),
    .mshr_req_addr_i     (req_addr),
    .mshr_clr_all_o      (clr_all),
    .mshr_add_o          (add_line),
    .mshr_put_wait_o     (put_wait),
    .mshr_clr_hit_o      (clr_hit),
    .mshr_cmp_addr_o     (cmp_addr),
    .stall_o             (stall_o),
    .merged_o            (merged_o),
    .l2_req_o            (l2_req_o)
  );

  dcache_mshr dcache_mshr_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .clr_all_i           (clr_all),
    .add_line_addr_i     (add_line),
    .put_wait_read_line_i(put_wait),
    .clr_hit_line_i      (clr_hit),
    .line_addr_i         (cmp_addr),
    .mshr_l2c_line_addr_o(req_addr),
    .hit_o               (hit),
    .req_available_o     (req_available),
    .full_o              (full_o),
    .pending_req_o       (pending_o)
  );

  default clocking cb @(posedge clk_i);
  endclocking

  // Controller issues one MSHR operation per cycle at most
  a_ctrl_onehot: assert property (
    disable iff (!rst_ni) $onehot0({clr_all, add_line, put_wait, clr_hit})
  );

endmodule

// File: sim/tb_dcache_miss_unit.sv
// --------------------
// Testbench of the L1 data cache miss unit
// Models L2, drives misses, refills and flushes, and checks the DUT
// against a scoreboard of outstanding lines with concurrent assertions
// --------------------

`timescale 1ns/1ps

`include "mshr_consts.svh"

module tb_dcache_miss_unit;

  localparam int ENTRIES = `L1C_MSHR_ENTRIES;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          flush_i;
  memory_pkg::miss_req_t         miss_i;
  memory_pkg::refill_t           refill_i;
  logic                          l2_stall_i;
  logic                          stall_o;
  logic                          merged_o;
  memory_pkg::l2_req_t           l2_req_o;
  logic                          full_o;
  memory_pkg::mshr_pending_req_t pending_o;

  // Scoreboard of outstanding lines
  // reqd marks a line already sent to L2
  logic [ENTRIES-1:0]     sb_valid;
  logic [ENTRIES-1:0]     sb_reqd;
  memory_pkg::line_addr_t sb_line [ENTRIES];

  // Expected responses from the miss rules
  logic miss_known;
  logic refill_known;
  logic req_line_ok;
  logic any_unreq;
  logic exp_full;
  logic exp_stall;
  logic exp_merged;
  logic exp_add;
  logic exp_req;
  int   sb_cnt;
  int   free_slot;
  int   req_slot;
  int   refill_slot;
  memory_pkg::mshr_pending_req_t exp_pending;

  integer                 seed;
  int                     err_cnt;
  int                     to_cnt;
  int                     req_seen;
  int                     req_target;
  string                  test_name;
  memory_pkg::line_addr_t line_a;
  memory_pkg::line_addr_t line_c;
  memory_pkg::line_addr_t line_d;
  memory_pkg::line_addr_t line_e;
  memory_pkg::line_addr_t line_x;
  memory_pkg::line_addr_t line_b [ENTRIES];

  dcache_miss_unit dcache_miss_unit_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .miss_i    (miss_i),
    .refill_i  (refill_i),
    .l2_stall_i(l2_stall_i),
    .stall_o   (stall_o),
    .merged_o  (merged_o),
    .l2_req_o  (l2_req_o),
    .full_o    (full_o),
    .pending_o (pending_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Lookups over the scoreboard for the current inputs
  always_comb begin
    miss_known = 1'b0;
    refill_known = 1'b0;
    req_line_ok = 1'b0;
    any_unreq = 1'b0;
    sb_cnt = 0;
    free_slot = 0;
    req_slot = 0;
    refill_slot = 0;
    exp_pending = '0;
    for (int k = ENTRIES - 1; k >= 0; k--) begin
      if (!sb_valid[k]) begin
        free_slot = k;
      end else begin
        sb_cnt = sb_cnt + 1;
        if (sb_line[k] == miss_i.line_addr) miss_known = 1'b1;
        if (sb_line[k] == refill_i.line_addr) begin
          refill_known = 1'b1;
          refill_slot = k;
        end
        if (sb_reqd[k]) begin
          exp_pending = exp_pending + memory_pkg::mshr_pending_req_t'(1);
        end else begin
          any_unreq = 1'b1;
          if (sb_line[k] == l2_req_o.line_addr) begin
            req_line_ok = 1'b1;
            req_slot = k;
          end
        end
      end
    end
    exp_full = (sb_cnt == ENTRIES);
    // Refill and flush own the cycle and hold any miss upstream
    exp_merged = miss_i.valid && !flush_i && !refill_i.valid && miss_known;
    exp_add = miss_i.valid && !flush_i && !refill_i.valid && !miss_known && !exp_full;
    exp_stall = miss_i.valid && (flush_i || refill_i.valid || (!miss_known && exp_full));
    exp_req = any_unreq && !l2_stall_i && !flush_i && !refill_i.valid && !exp_add;
  end

  // Scoreboard follows one event per edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sb_valid <= '0;
      sb_reqd <= '0;
    end else if (flush_i) begin
      sb_valid <= '0;
      sb_reqd <= '0;
    end else if (exp_add) begin
      sb_valid[free_slot] <= 1'b1;
      sb_reqd[free_slot] <= 1'b0;
      sb_line[free_slot] <= miss_i.line_addr;
    end else if (exp_req) begin
      sb_reqd[req_slot] <= 1'b1;
    end else if (refill_i.valid && refill_known) begin
      sb_valid[refill_slot] <= 1'b0;
      sb_reqd[refill_slot] <= 1'b0;
    end
  end

  // L2 side request counter
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) req_seen <= 0;
    else if (l2_req_o.valid) req_seen <= req_seen + 1;
  end

  a_stall: assert property (@(posedge clk_i) disable iff (!rst_ni) stall_o == exp_stall)
    else begin
      err_cnt++;
      $display("Fail %s stall_o expected %0b actual %0b", test_name,
               $sampled(exp_stall), $sampled(stall_o));
    end

  a_merged: assert property (@(posedge clk_i) disable iff (!rst_ni) merged_o == exp_merged)
    else begin
      err_cnt++;
      $display("Fail %s merged_o expected %0b actual %0b", test_name,
               $sampled(exp_merged), $sampled(merged_o));
    end

  a_full: assert property (@(posedge clk_i) disable iff (!rst_ni) full_o == exp_full)
    else begin
      err_cnt++;
      $display("Fail %s full_o expected %0b actual %0b", test_name,
               $sampled(exp_full), $sampled(full_o));
    end

  a_pending: assert property (@(posedge clk_i) disable iff (!rst_ni) pending_o == exp_pending)
    else begin
      err_cnt++;
      $display("Fail %s pending_o expected %0d actual %0d", test_name,
               $sampled(exp_pending), $sampled(pending_o));
    end

  a_req_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_req_o.valid == exp_req)
    else begin
      err_cnt++;
      $display("Fail %s l2_req_o.valid expected %0b actual %0b", test_name,
               $sampled(exp_req), $sampled(l2_req_o.valid));
    end

  // Each line goes to L2 once while outstanding
  a_req_line: assert property (@(posedge clk_i) disable iff (!rst_ni)
    l2_req_o.valid |-> req_line_ok)
    else begin
      err_cnt++;
      $display("Fail %s l2_req_o.line_addr expected an unrequested line actual %h",
               test_name, $sampled(l2_req_o.line_addr));
    end

  function automatic logic in_outstanding(input memory_pkg::line_addr_t line);
    logic found;
    found = 1'b0;
    for (int k = 0; k < ENTRIES; k++) begin
      if (sb_valid[k] && sb_line[k] == line) found = 1'b1;
    end
    return found;
  endfunction

  // Random line that is not outstanding
  task automatic new_line(output memory_pkg::line_addr_t line);
    line = memory_pkg::line_addr_t'($random(seed));
    while (in_outstanding(line)) begin
      line = memory_pkg::line_addr_t'($random(seed));
    end
  endtask

  // One cycle of pipeline and L2 strobes that drop on the next falling edge
  task automatic apply_cycle(input logic miss_v, input memory_pkg::line_addr_t miss_a,
                             input logic refill_v, input memory_pkg::line_addr_t refill_a,
                             input logic flush);
    @(negedge clk_i);
    miss_i.valid = miss_v;
    miss_i.line_addr = miss_a;
    refill_i.valid = refill_v;
    refill_i.line_addr = refill_a;
    flush_i = flush;
    @(negedge clk_i);
    miss_i.valid = 1'b0;
    refill_i.valid = 1'b0;
    flush_i = 1'b0;
  endtask

  task automatic set_l2_stall(input logic value);
    @(negedge clk_i);
    l2_stall_i = value;
  endtask

  // Wait until the L2 request counter reaches target
  task automatic wait_requests(input int target, input int limit);
    int cyc;
    cyc = 0;
    while (req_seen < target && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
    end
    if (req_seen < target) begin
      to_cnt++;
      $display("Timeout in %s: %0d L2 requests seen, %0d awaited", test_name, req_seen, target);
    end
  endtask

  initial begin
    seed = 32'h4fdab94c;
    err_cnt = 0;
    to_cnt = 0;
    test_name = "reset";
    rst_ni = 1'b0;
    flush_i = 1'b0;
    miss_i = '0;
    refill_i = '0;
    l2_stall_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "primary_miss";
    new_line(line_a);
    req_target = req_seen + 1;
    apply_cycle(1'b1, line_a, 1'b0, '0, 1'b0);
    wait_requests(req_target, 20);

    test_name = "merge_miss";
    apply_cycle(1'b1, line_a, 1'b0, '0, 1'b0);
    repeat (5) @(negedge clk_i);
    test_name = "refill_retire";
    apply_cycle(1'b0, '0, 1'b1, line_a, 1'b0);

    // Fill every entry while L2 pushes back
    test_name = "full_stall";
    set_l2_stall(1'b1);
    for (int i = 0; i < ENTRIES; i++) begin
      new_line(line_b[i]);
      apply_cycle(1'b1, line_b[i], 1'b0, '0, 1'b0);
    end
    new_line(line_x);
    apply_cycle(1'b1, line_x, 1'b0, '0, 1'b0);
    req_target = req_seen + ENTRIES;
    set_l2_stall(1'b0);
    wait_requests(req_target, 10 * ENTRIES);

    test_name = "refill_with_miss";
    new_line(line_c);
    apply_cycle(1'b1, line_c, 1'b1, line_b[1], 1'b0);
    req_target = req_seen + 1;
    apply_cycle(1'b1, line_c, 1'b0, '0, 1'b0);
    wait_requests(req_target, 20);

    // Unknown refill while one line is still to be requested
    test_name = "refill_unknown";
    apply_cycle(1'b0, '0, 1'b1, line_b[2], 1'b0);
    set_l2_stall(1'b1);
    new_line(line_d);
    apply_cycle(1'b1, line_d, 1'b0, '0, 1'b0);
    new_line(line_x);
    apply_cycle(1'b0, '0, 1'b1, line_x, 1'b0);
    req_target = req_seen + 1;
    set_l2_stall(1'b0);
    wait_requests(req_target, 20);

    // Flush with an unrequested line and a miss to an outstanding one
    test_name = "flush";
    set_l2_stall(1'b1);
    apply_cycle(1'b0, '0, 1'b1, line_b[0], 1'b0);
    new_line(line_e);
    apply_cycle(1'b1, line_e, 1'b0, '0, 1'b0);
    apply_cycle(1'b1, line_b[ENTRIES-1], 1'b0, '0, 1'b1);
    set_l2_stall(1'b0);
    repeat (10) @(negedge clk_i);

    $display("Closing report: %0d check errors, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+rtl
rtl/memory_pkg.sv
rtl/one_hot_encoder.sv
rtl/dcache_mshr.sv
rtl/dcache_miss_ctrl.sv
rtl/dcache_miss_unit.sv
sim/tb_dcache_miss_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the miss unit testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_dcache_miss_unit -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Done: no errors" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
